// ==== logic/nec_pkg.sv ====
// Shared widths, NEC timing constants and bus structs for the IR receiver.
// All durations are counted in sample ticks of roughly 70 us.
package nec_pkg;

  localparam int DELAY_W    = 12;  // Tick count between edges
  localparam int BYTE_W     = 8;
  localparam int FRAME_BITS = 32;

  // NEC nominal durations in ticks
  localparam logic [DELAY_W-1:0] UNIT_TICKS         = DELAY_W'(8);   // 562 us
  localparam logic [DELAY_W-1:0] ONE_SPACE_TICKS    = DELAY_W'(24);  // 1.69 ms
  localparam logic [DELAY_W-1:0] START_MARK_TICKS   = DELAY_W'(128); // 9 ms
  localparam logic [DELAY_W-1:0] START_SPACE_TICKS  = DELAY_W'(64);  // 4.5 ms
  localparam logic [DELAY_W-1:0] REPEAT_SPACE_TICKS = DELAY_W'(32);  // 2.25 ms

  // Counter start value after an edge, sets where the window is centered
  function automatic logic [DELAY_W-1:0] reload_offset_f(input logic [1:0] tolerance);
    case (tolerance)
      2'd0:    return DELAY_W'(1);
      2'd1:    return DELAY_W'(2);
      default: return DELAY_W'(4);
    endcase
  endfunction

  // Low bits ignored when comparing against the nominal counts
  function automatic logic [DELAY_W-1:0] delay_mask_f(input logic [1:0] tolerance);
    case (tolerance)
      2'd0:    return ~DELAY_W'(1);
      2'd1:    return ~DELAY_W'(3);
      default: return ~DELAY_W'(7);
    endcase
  endfunction

  typedef struct packed {
    logic       receiver_en;
    logic       repeat_en;
    logic       polarity;    // Idle level of the line is high
    logic [1:0] tolerance;
  } nec_cfg_t;

  typedef struct packed {
    logic               level;   // New filtered level, 1 is mark
    logic               timeout; // Counter had saturated
    logic [DELAY_W-1:0] delay;   // Masked tick count
  } ir_event_t;

  typedef struct packed {
    logic              is_repeat;
    logic [BYTE_W-1:0] addr;
    logic [BYTE_W-1:0] data;
  } nec_frame_t;

endpackage

// ==== logic/ir_sampler.sv ====
// Input conditioning for the IR line. Synchronizes the raw pin, flips it
// so that a mark reads as 1, then takes a 3-sample majority on each tick.
`timescale 1ns/1ns

module ir_sampler #(
  parameter int SYNC_STAGES = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic ir_i,
  input  logic polarity_i, // Idle high when set
  input  logic enable_i,
  input  logic tick_i,
  output logic level_o
);

  logic [SYNC_STAGES-1:0] sync_q;
  logic                   sample;
  logic [2:0]             hist_q;

  ////////////////////
  // Synchronizer
  ////////////////////
  always_ff @(posedge clk) begin
    sync_q[0] <= ir_i;
    for (int i = 1; i < SYNC_STAGES; i++) begin
      sync_q[i] <= sync_q[i-1];
    end
  end

  assign sample = sync_q[SYNC_STAGES-1] ^ polarity_i; // Mark becomes 1

  ////////////////////
  // Majority filter
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      hist_q <= '0;
    end else if (tick_i) begin
      hist_q <= {hist_q[1:0], sample};
    end
  end

  // Two of three samples agree
  assign level_o = (hist_q[0] & hist_q[1]) |
                   (hist_q[1] & hist_q[2]) |
                   (hist_q[2] & hist_q[0]);

endmodule

// ==== logic/edge_timer.sv ====
// Sample tick generator and level-length timer. Each change of the
// filtered level is reported as one event with the masked tick count of
// the level that just ended and a flag if the counter had saturated.
`timescale 1ns/1ns

module edge_timer #(
  parameter int TICK_DIV = 3500
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                level_i,
  input  logic [1:0]          tolerance_i,
  input  logic                enable_i,
  output logic                tick_o,
  output nec_pkg::ir_event_t  ev_o,
  output logic                ev_valid_o
);

  localparam int DIV_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

  logic [DIV_W-1:0]            div_q;
  logic [nec_pkg::DELAY_W-1:0] cnt_q;
  logic [nec_pkg::DELAY_W-1:0] next_cnt;
  logic                        last_q;
  logic                        full;
  logic                        edge_seen;

  // Prescaler, held cleared while disabled
  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      div_q <= '0;
    end else if (tick_o) begin
      div_q <= '0;
    end else begin
      div_q <= div_q + 1'b1;
    end
  end

  assign tick_o    = enable_i && (div_q == DIV_W'(TICK_DIV - 1));
  assign next_cnt  = cnt_q + 1'b1;
  assign full      = &cnt_q;
  assign edge_seen = (level_i != last_q);

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      last_q     <= 1'b0;
      cnt_q      <= '1;    // First edge reports a timeout
      ev_valid_o <= 1'b0;
    end else begin
      ev_valid_o <= tick_o && edge_seen;
      if (tick_o) begin
        last_q <= level_i;
        if (edge_seen) begin
          cnt_q <= nec_pkg::reload_offset_f(tolerance_i);
        end else if (!full) begin
          cnt_q <= next_cnt; // Saturates at all ones
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (tick_o && edge_seen) begin
      ev_o.level   <= level_i;
      ev_o.timeout <= full;
      ev_o.delay   <= next_cnt & nec_pkg::delay_mask_f(tolerance_i);
    end
  end

endmodule

// ==== logic/frame_fsm.sv ====
// NEC frame state machine. Steps on each timer event, checks the length
// of the level that ended against the nominal counts and drives the
// shifter. Any timing outside the window drops back to idle.
`timescale 1ns/1ns

module frame_fsm (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               enable_i,
  input  logic               repeat_en_i,
  input  nec_pkg::ir_event_t ev_i,
  input  logic               ev_valid_i,
  input  logic               last_bit_i,
  input  logic               check_ok_i,
  output logic               shift_clear_o,
  output logic               shift_en_o,
  output logic               shift_bit_o,
  output logic               frame_load_o,
  output logic               repeat_o
);

  typedef enum logic [2:0] {
    s_idle, s_start, s_bit_mark, s_bit_space, s_stop
  } state_t;

  state_t state_q;
  logic   init_to_q;  // No valid frame since the last timeout
  logic   repeat_q;
  logic   mark_end;
  logic   space_end;
  logic   is_unit;
  logic   is_one;

  assign mark_end  = !ev_i.timeout && !ev_i.level; // Mark just finished
  assign space_end = !ev_i.timeout && ev_i.level;
  assign is_unit   = (ev_i.delay == nec_pkg::UNIT_TICKS);
  assign is_one    = (ev_i.delay == nec_pkg::ONE_SPACE_TICKS);

  always_ff @(posedge clk) begin
    if (!rst_n || !enable_i) begin
      state_q       <= s_idle;
      init_to_q     <= 1'b1;
      repeat_q      <= 1'b0;
      shift_clear_o <= 1'b0;
      shift_en_o    <= 1'b0;
      frame_load_o  <= 1'b0;
      repeat_o      <= 1'b0;
    end else begin
      shift_clear_o <= 1'b0;
      shift_en_o    <= 1'b0;
      frame_load_o  <= 1'b0;
      if (ev_valid_i) begin
        state_q <= s_idle; // Default on bad timing
        case (state_q)
          s_idle: begin
            if (ev_i.timeout) init_to_q <= 1'b1;
            if (mark_end && ev_i.delay == nec_pkg::START_MARK_TICKS) state_q <= s_start;
          end
          s_start: begin
            if (space_end && ev_i.delay == nec_pkg::START_SPACE_TICKS) begin
              state_q       <= s_bit_mark;
              repeat_q      <= 1'b0;
              shift_clear_o <= 1'b1;
            end else if (space_end && ev_i.delay == nec_pkg::REPEAT_SPACE_TICKS &&
                         repeat_en_i && !init_to_q) begin
              state_q  <= s_stop;  // Repeat code, only the stop mark follows
              repeat_q <= 1'b1;
            end
          end
          s_bit_mark: begin
            if (mark_end && is_unit) state_q <= s_bit_space;
          end
          s_bit_space: begin
            if (space_end && (is_unit || is_one)) begin
              shift_en_o <= 1'b1;
              state_q    <= last_bit_i ? s_stop : s_bit_mark;
            end
          end
          s_stop: begin
            if (mark_end && is_unit && (repeat_q || check_ok_i)) begin
              frame_load_o <= 1'b1;
              repeat_o     <= repeat_q;
              if (!repeat_q) init_to_q <= 1'b0;
            end
          end
          default: state_q <= s_idle;
        endcase
      end
    end
  end

  // Bit value rides along with shift_en_o
  always_ff @(posedge clk) begin
    if (ev_valid_i) shift_bit_o <= is_one;
  end

endmodule

// ==== logic/frame_shifter.sv ====
// Frame shift register with the address/data complement checks and the
// output frame register. Bits arrive LSB first and shift in from the top.
`timescale 1ns/1ns

module frame_shifter (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                shift_clear_i,
  input  logic                shift_en_i,
  input  logic                shift_bit_i,
  input  logic                frame_load_i,
  input  logic                repeat_i,
  output logic                last_bit_o,
  output logic                check_ok_o,
  output nec_pkg::nec_frame_t frame_o,
  output logic                frame_valid_o
);

  localparam logic [nec_pkg::FRAME_BITS-1:0] MARKER = {1'b1, {(nec_pkg::FRAME_BITS-1){1'b0}}};

  logic [nec_pkg::FRAME_BITS-1:0] shift_q;

  always_ff @(posedge clk) begin
    if (!rst_n || shift_clear_i) begin
      shift_q <= MARKER;
    end else if (shift_en_i) begin
      shift_q <= {shift_bit_i, shift_q[nec_pkg::FRAME_BITS-1:1]};
    end
  end

  assign last_bit_o = shift_q[0]; // Marker about to drop out
  assign check_ok_o = (shift_q[7:0] == ~shift_q[15:8]) &&
                      (shift_q[23:16] == ~shift_q[31:24]);

  ////////////////////
  // Output frame
  ////////////////////
  always_ff @(posedge clk) begin
    if (frame_load_i) begin
      frame_o.is_repeat <= repeat_i;
      if (!repeat_i) begin // Repeat keeps last accepted bytes
        frame_o.addr <= shift_q[7:0];
        frame_o.data <= shift_q[23:16];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) frame_valid_o <= 1'b0;
    else        frame_valid_o <= frame_load_i;
  end

endmodule

// ==== logic/nec_ir_receiver.sv ====
// NEC infrared receiver top level. Feed the raw IR pin on ir_i and the
// configuration levels on cfg_i; each decoded frame or repeat code comes
// out as a one-cycle frame_valid_o strobe with frame_o.
`timescale 1ns/1ns

module nec_ir_receiver #(
  parameter int SYNC_STAGES = 2,
  parameter int TICK_DIV    = 3500 // About 70 us at 50 MHz
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ir_i,
  input  nec_pkg::nec_cfg_t   cfg_i,
  output nec_pkg::nec_frame_t frame_o,
  output logic                frame_valid_o
);

  logic               tick;
  logic               level;
  nec_pkg::ir_event_t ev;
  logic               ev_valid;
  logic               shift_clear;
  logic               shift_en;
  logic               shift_bit;
  logic               frame_load;
  logic               frame_repeat;
  logic               last_bit;
  logic               check_ok;

  ir_sampler #(.SYNC_STAGES(SYNC_STAGES)) sampler_i (
    .clk(clk), .rst_n(rst_n), .ir_i(ir_i), .polarity_i(cfg_i.polarity),
    .enable_i(cfg_i.receiver_en), .tick_i(tick), .level_o(level)
  );

  edge_timer #(.TICK_DIV(TICK_DIV)) timer_i (
    .clk(clk), .rst_n(rst_n), .level_i(level), .tolerance_i(cfg_i.tolerance),
    .enable_i(cfg_i.receiver_en), .tick_o(tick), .ev_o(ev), .ev_valid_o(ev_valid)
  );

  frame_fsm fsm_i (
    .clk(clk), .rst_n(rst_n), .enable_i(cfg_i.receiver_en),
    .repeat_en_i(cfg_i.repeat_en), .ev_i(ev), .ev_valid_i(ev_valid),
    .last_bit_i(last_bit), .check_ok_i(check_ok), .shift_clear_o(shift_clear),
    .shift_en_o(shift_en), .shift_bit_o(shift_bit), .frame_load_o(frame_load),
    .repeat_o(frame_repeat)
  );

  frame_shifter shifter_i (
    .clk(clk), .rst_n(rst_n), .shift_clear_i(shift_clear), .shift_en_i(shift_en),
    .shift_bit_i(shift_bit), .frame_load_i(frame_load), .repeat_i(frame_repeat),
    .last_bit_o(last_bit), .check_ok_o(check_ok), .frame_o(frame_o),
    .frame_valid_o(frame_valid_o)
  );

endmodule

// ==== tb/nec_ir_receiver_sva.sv ====
// Assertions on the receiver strobe, bound into the top level. The
// failure count is read by the testbench at the end of the run.
`timescale 1ns/1ns

module nec_ir_receiver_sva (
  input logic              clk,
  input logic              rst_n,
  input nec_pkg::nec_cfg_t cfg_i,
  input logic              frame_valid_o
);

  int fail_cnt = 0;

  single_strobe: assert property (@(posedge clk) disable iff (!rst_n)
    frame_valid_o |=> !frame_valid_o)
    else begin
      $error("frame_valid_o high on two cycles");
      fail_cnt++;
    end

  // Two cycles of pipeline after the enable drops
  quiet_disabled: assert property (@(posedge clk) disable iff (!rst_n)
    (!cfg_i.receiver_en && !$past(cfg_i.receiver_en) && !$past(cfg_i.receiver_en, 2))
    |-> !frame_valid_o)
    else begin
      $error("frame_valid_o high while disabled");
      fail_cnt++;
    end

  quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !frame_valid_o)
    else begin
      $error("frame_valid_o high during reset");
      fail_cnt++;
    end

endmodule

bind nec_ir_receiver nec_ir_receiver_sva sva_i (
  .clk(clk), .rst_n(rst_n), .cfg_i(cfg_i), .frame_valid_o(frame_valid_o)
);

// ==== tb/nec_ir_receiver_tb.sv ====
// Testbench for the NEC IR receiver. Reads one test per line from the
// stimulus file, builds the IR waveform tick by tick on ir_i and checks
// each frame strobe against the bytes and flags given in that line.
`timescale 1ns/1ns

module nec_ir_receiver_tb;

  localparam int TICK_DIV    = 4;
  localparam int SYNC_STAGES = 2;
  localparam int WAIT_TICKS  = 2000;
  localparam int UNIT        = 8;    // NEC timings in ticks
  localparam int ONE_SPACE   = 24;
  localparam int START_MARK  = 128;
  localparam int START_SPACE = 64;
  localparam int REP_SPACE   = 32;
  localparam int BAD_SPACE   = 48;
  localparam int TAIL        = 40;   // Idle after the stop mark
  localparam int K_REPEAT    = 1;
  localparam int K_CORRUPT   = 2;
  localparam int K_BAD       = 3;

  logic                clk;
  logic                rst_n;
  logic                ir_i;
  nec_pkg::nec_cfg_t   cfg_i;
  nec_pkg::nec_frame_t frame_o;
  logic                frame_valid_o;

  nec_pkg::nec_frame_t seen_q[$]; // Strobes seen by the monitor
  int errors;
  int tests;
  int failed;
  int spread;                     // Jitter range of the current test

  nec_ir_receiver #(.SYNC_STAGES(SYNC_STAGES), .TICK_DIV(TICK_DIV)) dut_i (
    .clk(clk), .rst_n(rst_n), .ir_i(ir_i), .cfg_i(cfg_i),
    .frame_o(frame_o), .frame_valid_o(frame_valid_o)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Strobe sampled mid-cycle
  always @(negedge clk) begin
    if (rst_n && frame_valid_o) seen_q.push_back(frame_o);
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp);
      errors++;
    end
  endtask

  function automatic int jit(input int nominal);
    return nominal + int'($urandom_range(2 * spread)) - spread;
  endfunction

  ////////////////////
  // Waveform
  ////////////////////
  task automatic hold(input logic mark, input int ticks);
    ir_i <= mark ^ cfg_i.polarity;
    repeat (ticks * TICK_DIV) @(posedge clk);
  endtask

  task automatic send_byte(input logic [7:0] value);
    for (int i = 0; i < 8; i++) begin  // LSB first
      hold(1'b1, jit(UNIT));
      hold(1'b0, jit(value[i] ? ONE_SPACE : UNIT));
    end
  endtask

  task automatic send_frame(input logic [7:0] addr, input logic [7:0] data,
                            input logic [7:0] dcheck, input int start_space);
    hold(1'b1, jit(START_MARK));
    hold(1'b0, jit(start_space));
    send_byte(addr);
    send_byte(~addr);
    send_byte(data);
    send_byte(dcheck);
    hold(1'b1, jit(UNIT));  // Stop mark
    hold(1'b0, TAIL);
  endtask

  task automatic send_repeat();
    hold(1'b1, jit(START_MARK));
    hold(1'b0, jit(REP_SPACE));
    hold(1'b1, jit(UNIT));
    hold(1'b0, TAIL);
  endtask

  ////////////////////
  // Response checks
  ////////////////////
  task automatic wait_strobe(output bit got);
    int n;
    n = 0;
    while (seen_q.size() == 0 && n < WAIT_TICKS * TICK_DIV) begin
      @(posedge clk);
      n++;
    end
    got = (seen_q.size() != 0);
  endtask

  task automatic expect_frame(input logic [7:0] addr, input logic [7:0] data, input logic rep);
    bit                  got;
    nec_pkg::nec_frame_t f;
    wait_strobe(got);
    if (!got) begin
      $display("No frame strobe within %0d ticks", WAIT_TICKS);
      errors++;
    end else begin
      repeat (20 * TICK_DIV) @(posedge clk); // Room for a second strobe
      check("strobe count", 32'(seen_q.size()), 32'd1);
      f = seen_q.pop_front();
      check("frame_o.addr", 32'(f.addr), 32'(addr));
      check("frame_o.data", 32'(f.data), 32'(data));
      check("frame_o.is_repeat", 32'(f.is_repeat), 32'(rep));
      seen_q.delete();
    end
  endtask

  task automatic expect_none();
    bit got;
    wait_strobe(got);
    check("strobe count", 32'(seen_q.size()), 32'd0);
    seen_q.delete();
  endtask

  task automatic run_test(input int kind, input logic [1:0] tol, input logic rep_en,
                          input logic pol, input logic [7:0] addr, input logic [7:0] data,
                          input int exp_kind);
    int         err_before;
    logic [7:0] dcheck;
    err_before = errors;
    dcheck     = (kind == K_CORRUPT) ? (~data ^ 8'h04) : ~data;
    // Receiver off while config and idle level change
    cfg_i <= '{receiver_en: 1'b0, repeat_en: rep_en, polarity: pol, tolerance: tol};
    ir_i  <= pol;
    repeat (4 * TICK_DIV) @(posedge clk);
    send_frame(addr, data, ~data, START_SPACE); // Ignored while disabled
    cfg_i.receiver_en <= 1'b1;
    repeat (10 * TICK_DIV) @(posedge clk);
    seen_q.delete();
    if (kind == K_REPEAT) begin
      send_repeat();  // No valid frame yet, so refused
      expect_none();
      send_frame(addr, data, ~data, START_SPACE);
      expect_frame(addr, data, 1'b0);
      send_repeat();
    end else begin
      send_frame(addr, data, dcheck, (kind == K_BAD) ? BAD_SPACE : START_SPACE);
    end
    if (exp_kind == 0) expect_none();
    else               expect_frame(addr, data, exp_kind == 2);
    tests++;
    if (errors != err_before) failed++;
    $display("test %0d kind %0d: %s", tests, kind, (errors == err_before) ? "ok" : "errors");
  endtask

  initial begin
    int         fd;
    int         kind;
    int         exp_kind;
    logic [1:0] tol;
    logic       rep_en;
    logic       pol;
    logic [7:0] addr;
    logic [7:0] data;
    string      line;
    rst_n  <= 1'b0;
    ir_i   <= 1'b0;
    cfg_i  <= '0;
    errors = 0;
    tests  = 0;
    failed = 0;
    void'($urandom(32'h5983_5931));
    repeat (4) @(posedge clk);
    rst_n <= 1'b1;
    fd = $fopen("tb/nec_stim.txt", "r");
    if (fd == 0) begin
      $display("Cannot open the stimulus file tb/nec_stim.txt");
      errors++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        if ($fgets(line, fd) != 0 &&
            $sscanf(line, "%h %h %h %h %h %h %h %h", kind, tol, rep_en, pol,
                    addr, data, spread, exp_kind) == 8) begin
          run_test(kind, tol, rep_en, pol, addr, data, exp_kind);
        end
      end
      $fclose(fd);
    end
    errors += dut_i.sva_i.fail_cnt;
    $display("%0d tests, %0d failed, %0d errors", tests, failed, errors);
    if (errors == 0 && tests > 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

// ==== tb/nec_stim.txt ====
# kind tolerance repeat_en polarity addr data jitter expect (all hex)
# kind 0 frame 1 repeat 2 corrupt-check 3 bad-timing, expect 0 none 1 frame 2 repeat
0 0 0 0 a5 3c 0 1
0 0 0 0 00 ff 0 1
0 2 0 0 5a c3 1 1
0 2 1 0 12 e7 1 1
0 1 0 0 81 7e 1 1
2 0 0 0 a5 3c 0 0
1 0 1 0 40 11 0 2
1 2 1 0 9d 62 1 2
1 0 0 0 40 11 0 0
0 0 0 1 a5 3c 0 1
1 0 1 1 33 cc 0 2
3 0 0 0 a5 3c 0 0

// ==== project.f ====
logic/nec_pkg.sv
logic/ir_sampler.sv
logic/edge_timer.sv
logic/frame_fsm.sv
logic/frame_shifter.sv
logic/nec_ir_receiver.sv
tb/nec_ir_receiver_sva.sv
tb/nec_ir_receiver_tb.sv

// ==== Makefile ====
# Verilator build and run of the NEC IR receiver testbench
VERILATOR  ?= verilator
TOP        ?= nec_ir_receiver_tb
RTL_TOP    ?= nec_ir_receiver
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert -Wall
RUN_ARGS   ?= +verilator+error+limit+100
PASS_MSG   ?= sim passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS))"; echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_MSG)'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
